//--- pci_wb_pkg.sv
// Bus widths, PCI command code and shared vector types for the PCI to Wishbone bridge
package pci_wb_pkg;

   // Bus widths
   localparam int PCI_AD_W  = 32;
   localparam int PCI_CBE_W = 4;
   localparam int WB_SEL_W  = 4;

   // Address/data word as seen on AD and on the Wishbone side
   typedef logic [PCI_AD_W-1:0] pci_ad_t;

   // Command in the address phase, active-low byte enables in data phases
   typedef logic [PCI_CBE_W-1:0] pci_cbe_t;

   // Active-high Wishbone byte select
   typedef logic [WB_SEL_W-1:0] wb_sel_t;

   // Memory write command
   localparam pci_cbe_t PCI_CMD_MEM_WRITE = 4'b0111;

   // Byte address step between data phases of a linear burst
   localparam pci_ad_t ADDR_STEP = 32'd4;

endpackage

//--- post_wr_if.sv
// Posted write word interface with valid/ready handshake and src/dst modports
interface post_wr_if;
   import pci_wb_pkg::*;

   pci_ad_t adr;
   pci_ad_t dat;
   wb_sel_t sel;
   logic    valid;
   logic    ready;

   // Producer side
   modport src (
      output adr,
      output dat,
      output sel,
      output valid,
      input  ready
   );

   // Consumer side
   modport dst (
      input  adr,
      input  dat,
      input  sel,
      input  valid,
      output ready
   );

endinterface

//--- pci_target_wr.sv
// PCI target write FSM with window decode, data phases, disconnect and parity check
module pci_target_wr #(
   parameter pci_wb_pkg::pci_ad_t BAR_BASE      = 32'h8000_0000,
   parameter integer              BAR_SIZE_LOG2 = 12
) (
   input  logic                 pci_clk_i,
   input  logic                 arst_n_i,
   input  pci_wb_pkg::pci_ad_t  ad_i,
   input  pci_wb_pkg::pci_cbe_t cbe_n_i,
   input  logic                 par_i,
   input  logic                 frame_n_i,
   input  logic                 irdy_n_i,
   output logic                 devsel_n_o,
   output logic                 trdy_n_o,
   output logic                 stop_n_o,
   output logic                 tgt_oe_o,
   output logic                 perr_n_o,
   output logic                 perr_oe_o,
   post_wr_if.src               wr
);
   import pci_wb_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_ignore,
      st_data,
      st_turn
   } state_t;

   state_t   state_q;
   pci_ad_t  addr_q;
   logic     disc_q;
   logic     addr_hit;
   logic     at_end;
   logic     xfer;
   logic     par_chk_q;
   pci_ad_t  par_ad_q;
   pci_cbe_t par_cbe_q;
   logic     par_err;
   logic     perr_q;

   function automatic logic in_window(input pci_ad_t a);
      return (a >> BAR_SIZE_LOG2) == (BAR_BASE >> BAR_SIZE_LOG2);
   endfunction

   // Decode of the address phase
   assign addr_hit = (cbe_n_i == PCI_CMD_MEM_WRITE) && in_window(ad_i);

   // Next burst address would fall outside the window
   assign at_end = !in_window(addr_q + ADDR_STEP);

   // Target control pins, only meaningful while tgt_oe_o is high
   assign devsel_n_o = (state_q != st_data);
   assign trdy_n_o   = !((state_q == st_data) && !disc_q && wr.ready);
   assign stop_n_o   = !((state_q == st_data) && (disc_q || (at_end && wr.ready)));
   assign tgt_oe_o   = (state_q == st_data) || (state_q == st_turn);

   // Master holds AD and CBE stable while irdy is low, so the word is stable too
   assign wr.valid = (state_q == st_data) && !disc_q && !irdy_n_i;
   assign wr.adr   = addr_q;
   assign wr.dat   = ad_i;
   assign wr.sel   = ~cbe_n_i;

   assign xfer = wr.valid && wr.ready;

   always_ff @(posedge pci_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= st_idle;
         addr_q  <= '0;
         disc_q  <= 1'b0;
      end else begin
         case (state_q)
            st_idle: begin
               if (!frame_n_i) begin
                  if (addr_hit) begin
                     state_q <= st_data;
                     addr_q  <= {ad_i[PCI_AD_W-1:2], 2'b00};
                  end else begin
                     state_q <= st_ignore;
                  end
               end
            end
            // Not ours, wait for the bus to go idle
            st_ignore: begin
               if (frame_n_i && irdy_n_i) begin
                  state_q <= st_idle;
               end
            end
            st_data: begin
               if (xfer) begin
                  addr_q <= addr_q + ADDR_STEP;
               end
               if (xfer && frame_n_i) begin
                  state_q <= st_turn;
               end else if (xfer && at_end) begin
                  disc_q <= 1'b1;
               end else if (disc_q && frame_n_i) begin
                  state_q <= st_turn;
               end
            end
            st_turn: begin
               state_q <= st_idle;
               disc_q  <= 1'b0;
            end
            default: begin
               state_q <= st_idle;
            end
         endcase
      end
   end

   // Copy of the last completed phase for the late parity check
   always_ff @(posedge pci_clk_i) begin
      if (xfer) begin
         par_ad_q  <= ad_i;
         par_cbe_q <= cbe_n_i;
      end
   end

   // Odd count of ones over AD, CBE and PAR
   assign par_err = par_chk_q && (^{par_ad_q, par_cbe_q, par_i});

   always_ff @(posedge pci_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         par_chk_q <= 1'b0;
         perr_q    <= 1'b0;
      end else begin
         par_chk_q <= xfer;
         perr_q    <= par_err;
      end
   end

   assign perr_n_o  = !perr_q;
   assign perr_oe_o = perr_q;

endmodule

//--- post_wr_fifo.sv
// First-word-fall-through buffer of posted write words
module post_wr_fifo #(
   parameter integer FIFO_DEPTH_LOG2 = 2
) (
   input  logic   pci_clk_i,
   input  logic   arst_n_i,
   post_wr_if.dst wr_in,
   post_wr_if.src wr_out
);
   import pci_wb_pkg::*;

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

   pci_ad_t adr_mem [DEPTH];
   pci_ad_t dat_mem [DEPTH];
   wb_sel_t sel_mem [DEPTH];

   logic [FIFO_DEPTH_LOG2-1:0] wr_ptr_q;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr_q;
   logic                       full_q;
   logic                       empty;
   logic                       push;
   logic                       pop;

   assign empty = (wr_ptr_q == rd_ptr_q) && !full_q;

   assign wr_in.ready  = !full_q;
   assign wr_out.valid = !empty;

   assign push = wr_in.valid && wr_in.ready;
   assign pop  = wr_out.valid && wr_out.ready;

   // Head word is presented straight from storage
   assign wr_out.adr = adr_mem[rd_ptr_q];
   assign wr_out.dat = dat_mem[rd_ptr_q];
   assign wr_out.sel = sel_mem[rd_ptr_q];

   always_ff @(posedge pci_clk_i) begin
      if (push) begin
         adr_mem[wr_ptr_q] <= wr_in.adr;
         dat_mem[wr_ptr_q] <= wr_in.dat;
         sel_mem[wr_ptr_q] <= wr_in.sel;
      end
   end

   always_ff @(posedge pci_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         full_q   <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // Full only changes when exactly one side moves
         if (push && !pop && (wr_ptr_q + 1'b1 == rd_ptr_q)) begin
            full_q <= 1'b1;
         end else if (pop && !push) begin
            full_q <= 1'b0;
         end
      end
   end

endmodule

//--- wb_wr_master.sv
// Wishbone master issuing one single write cycle per buffered word
module wb_wr_master (
   input  logic                pci_clk_i,
   input  logic                arst_n_i,
   post_wr_if.dst              wr,
   output pci_wb_pkg::pci_ad_t wb_adr_o,
   output pci_wb_pkg::pci_ad_t wb_dat_o,
   output pci_wb_pkg::wb_sel_t wb_sel_o,
   output logic                wb_cyc_o,
   output logic                wb_stb_o,
   output logic                wb_we_o,
   input  logic                wb_ack_i
);

   typedef enum logic {
      st_idle,
      st_busy
   } state_t;

   state_t state_q;

   always_ff @(posedge pci_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= st_idle;
      end else begin
         case (state_q)
            st_idle: begin
               if (wr.valid) begin
                  state_q <= st_busy;
               end
            end
            // Hold the cycle until the slave acks
            st_busy: begin
               if (wb_ack_i) begin
                  state_q <= st_idle;
               end
            end
            default: begin
               state_q <= st_idle;
            end
         endcase
      end
   end

   // Word is captured when the cycle starts, kept stable until ack
   always_ff @(posedge pci_clk_i) begin
      if ((state_q == st_idle) && wr.valid) begin
         wb_adr_o <= wr.adr;
         wb_dat_o <= wr.dat;
         wb_sel_o <= wr.sel;
      end
   end

   assign wb_cyc_o = (state_q == st_busy);
   assign wb_stb_o = (state_q == st_busy);
   assign wb_we_o  = (state_q == st_busy);

   // Pop on the ack edge only. the idle cycle after it drops cyc and stb
   assign wr.ready = (state_q == st_busy) && wb_ack_i;

endmodule

//--- pci_wb_bridge.sv
// Top level of the posted-write PCI target to Wishbone master bridge
module pci_wb_bridge #(
   parameter pci_wb_pkg::pci_ad_t BAR_BASE        = 32'h8000_0000,
   parameter integer              BAR_SIZE_LOG2   = 12,
   parameter integer              FIFO_DEPTH_LOG2 = 2
) (
   input  logic                 pci_clk_i,
   input  logic                 arst_n_i,
   // PCI target pins, each output with its own enable
   input  pci_wb_pkg::pci_ad_t  ad_i,
   input  pci_wb_pkg::pci_cbe_t cbe_n_i,
   input  logic                 par_i,
   input  logic                 frame_n_i,
   input  logic                 irdy_n_i,
   output logic                 devsel_n_o,
   output logic                 trdy_n_o,
   output logic                 stop_n_o,
   output logic                 tgt_oe_o,
   output logic                 perr_n_o,
   output logic                 perr_oe_o,
   // Wishbone master, clocked from the PCI clock
   output pci_wb_pkg::pci_ad_t  wb_adr_o,
   output pci_wb_pkg::pci_ad_t  wb_dat_o,
   output pci_wb_pkg::wb_sel_t  wb_sel_o,
   output logic                 wb_cyc_o,
   output logic                 wb_stb_o,
   output logic                 wb_we_o,
   input  logic                 wb_ack_i
);

   post_wr_if req_wr ();
   post_wr_if drain_wr ();

   pci_target_wr #(
      .BAR_BASE      (BAR_BASE),
      .BAR_SIZE_LOG2 (BAR_SIZE_LOG2)
   ) u_target (
      .pci_clk_i  (pci_clk_i),
      .arst_n_i   (arst_n_i),
      .ad_i       (ad_i),
      .cbe_n_i    (cbe_n_i),
      .par_i      (par_i),
      .frame_n_i  (frame_n_i),
      .irdy_n_i   (irdy_n_i),
      .devsel_n_o (devsel_n_o),
      .trdy_n_o   (trdy_n_o),
      .stop_n_o   (stop_n_o),
      .tgt_oe_o   (tgt_oe_o),
      .perr_n_o   (perr_n_o),
      .perr_oe_o  (perr_oe_o),
      .wr         (req_wr.src)
   );

   post_wr_fifo #(
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) u_fifo (
      .pci_clk_i (pci_clk_i),
      .arst_n_i  (arst_n_i),
      .wr_in     (req_wr.dst),
      .wr_out    (drain_wr.src)
   );

   wb_wr_master u_wb (
      .pci_clk_i (pci_clk_i),
      .arst_n_i  (arst_n_i),
      .wr        (drain_wr.dst),
      .wb_adr_o  (wb_adr_o),
      .wb_dat_o  (wb_dat_o),
      .wb_sel_o  (wb_sel_o),
      .wb_cyc_o  (wb_cyc_o),
      .wb_stb_o  (wb_stb_o),
      .wb_we_o   (wb_we_o),
      .wb_ack_i  (wb_ack_i)
   );

endmodule

//--- tb_bridge_asserts.sv
// Concurrent assertions on the bridge ports, bound into pci_wb_bridge
module tb_bridge_asserts (
   input logic                pci_clk_i,
   input logic                arst_n_i,
   input logic                devsel_n_o,
   input logic                trdy_n_o,
   input logic                perr_oe_o,
   input pci_wb_pkg::pci_ad_t wb_adr_o,
   input pci_wb_pkg::pci_ad_t wb_dat_o,
   input pci_wb_pkg::wb_sel_t wb_sel_o,
   input logic                wb_cyc_o,
   input logic                wb_stb_o,
   input logic                wb_ack_i
);

   trdy_needs_devsel: assert property (@(posedge pci_clk_i) disable iff (!arst_n_i)
      !trdy_n_o |-> !devsel_n_o)
      else $error("trdy asserted without devsel");

   stb_needs_cyc: assert property (@(posedge pci_clk_i) disable iff (!arst_n_i)
      wb_stb_o |-> wb_cyc_o)
      else $error("stb asserted without cyc");

   // Slave may sample any time before ack
   wb_word_stable: assert property (@(posedge pci_clk_i) disable iff (!arst_n_i)
      (wb_stb_o && !wb_ack_i) |=> ($stable(wb_adr_o) && $stable(wb_dat_o) && $stable(wb_sel_o)))
      else $error("Wishbone word changed before ack");

   perr_one_cycle: assert property (@(posedge pci_clk_i) disable iff (!arst_n_i)
      perr_oe_o |=> !perr_oe_o)
      else $error("PERR held longer than one cycle");

endmodule

bind pci_wb_bridge tb_bridge_asserts u_asserts (
   .pci_clk_i  (pci_clk_i),
   .arst_n_i   (arst_n_i),
   .devsel_n_o (devsel_n_o),
   .trdy_n_o   (trdy_n_o),
   .perr_oe_o  (perr_oe_o),
   .wb_adr_o   (wb_adr_o),
   .wb_dat_o   (wb_dat_o),
   .wb_sel_o   (wb_sel_o),
   .wb_cyc_o   (wb_cyc_o),
   .wb_stb_o   (wb_stb_o),
   .wb_ack_i   (wb_ack_i)
);

//--- tb_pci_wb_bridge.sv
// Testbench with PCI master model, Wishbone slave model, reference function and checker
module tb_pci_wb_bridge;
   import pci_wb_pkg::*;

   localparam pci_ad_t BAR_BASE = 32'h8000_0000;
   localparam integer BAR_SIZE_LOG2 = 8;
   localparam integer FIFO_DEPTH_LOG2 = 2;
   localparam int ACK_DELAY_MAX = 6;

   logic clk = 1'b0;
   logic arst_n, frame_n, irdy_n, par, wb_ack;
   pci_ad_t ad, wb_adr, wb_dat;
   pci_cbe_t cbe_n;
   wb_sel_t wb_sel;
   logic devsel_n, trdy_n, stop_n, tgt_oe, perr_n, perr_oe, wb_cyc, wb_stb, wb_we;

   integer seed = 32'h577e592e;
   integer ack_seed = 32'h577e592f;
   string cur_test = "none";
   int cycle_cnt;
   logic par_next, par_due;
   int fixed_delay;
   pci_ad_t exp_adr[$], exp_dat[$], obs_adr[$], obs_dat[$];
   wb_sel_t exp_sel[$], obs_sel[$];
   int perr_cycles[$];

   pci_wb_bridge #(
      .BAR_BASE        (BAR_BASE),
      .BAR_SIZE_LOG2   (BAR_SIZE_LOG2),
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) u_dut (
      .pci_clk_i (clk), .arst_n_i (arst_n), .ad_i (ad), .cbe_n_i (cbe_n), .par_i (par),
      .frame_n_i (frame_n), .irdy_n_i (irdy_n), .devsel_n_o (devsel_n), .trdy_n_o (trdy_n),
      .stop_n_o (stop_n), .tgt_oe_o (tgt_oe), .perr_n_o (perr_n), .perr_oe_o (perr_oe),
      .wb_adr_o (wb_adr), .wb_dat_o (wb_dat), .wb_sel_o (wb_sel), .wb_cyc_o (wb_cyc),
      .wb_stb_o (wb_stb), .wb_we_o (wb_we), .wb_ack_i (wb_ack)
   );

   always #20 clk = ~clk;

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   // PERR and its enable are driven together
   always @(negedge clk) begin
      if (arst_n && (!perr_n || perr_oe)) begin
         check_value("perr_oe_o", 32'd1, 32'(perr_oe));
         check_value("perr_n_o", 32'd0, 32'(perr_n));
         perr_cycles.push_back(cycle_cnt);
      end
   end

   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
         $display("Verification failed");
         $fatal(1);
      end
   endtask

   function automatic bit in_win(input pci_ad_t a);
      return (a >= BAR_BASE) && ((a - BAR_BASE) < (32'd1 << BAR_SIZE_LOG2));
   endfunction

   // Expected Wishbone write of one data phase or zero when the phase is not ours
   function automatic bit ref_write(input pci_cbe_t cmd, input pci_ad_t start, input int idx,
                                    input pci_ad_t dat, input pci_cbe_t be,
                                    output pci_ad_t adr, output pci_ad_t wdat,
                                    output wb_sel_t sel);
      adr  = start + 32'(idx) * 32'd4;
      wdat = dat;
      sel  = ~be;
      return (cmd == PCI_CMD_MEM_WRITE) && in_win(start) && in_win(adr);
   endfunction

   task automatic next_cycle();
      @(negedge clk);
      if (par_due) begin
         par = par_next;
         par_due = 1'b0;
      end
   endtask

   // PCI master model for one burst that ends early on stop or a missing devsel
   task automatic run_burst(input pci_cbe_t cmd, input pci_ad_t start, input int n,
                            input int bad_phase, output int done_cnt, output int waits,
                            output int stop_phase, output int bad_cycle);
      int idx, tries, nodev;
      bit finished, phase_done, aborted;
      logic [31:0] rnd;
      pci_ad_t dat, e_adr, e_dat;
      pci_cbe_t be;
      wb_sel_t e_sel;
      done_cnt = 0;
      waits = 0;
      stop_phase = -1;
      bad_cycle = -1;
      idx = 0;
      nodev = 0;
      finished = 1'b0;
      aborted = 1'b0;
      next_cycle();
      frame_n = 1'b0;
      ad = start;
      cbe_n = cmd;
      next_cycle();
      while (!finished) begin
         rnd = $random(seed);
         dat = rnd;
         rnd = $random(seed);
         be = rnd[3:0];
         ad = dat;
         cbe_n = be;
         irdy_n = 1'b0;
         frame_n = (idx == n - 1);
         phase_done = 1'b0;
         tries = 0;
         while (!phase_done) begin
            #1;
            if (!devsel_n && !trdy_n) begin
               if (!ref_write(cmd, start, idx, dat, be, e_adr, e_dat, e_sel))
                  fail_stop("Target accepted a data phase outside its window");
               check_value("tgt_oe_o", 32'd1, 32'(tgt_oe));
               exp_adr.push_back(e_adr);
               exp_dat.push_back(e_dat);
               exp_sel.push_back(e_sel);
               par_next = (^{dat, be}) ^ (idx == bad_phase);
               par_due = 1'b1;
               if (idx == bad_phase) bad_cycle = cycle_cnt + 1;
               if (!stop_n) stop_phase = idx;
               done_cnt++;
               phase_done = 1'b1;
            end else begin
               if (devsel_n) begin
                  nodev++;
                  check_value("tgt_oe_o", 32'd0, 32'(tgt_oe));
               end else begin
                  waits++;
               end
               tries++;
               if (nodev >= 5) begin
                  aborted = 1'b1;
                  phase_done = 1'b1;
               end else if (tries > 64) begin
                  fail_stop("Timeout waiting for a data phase to complete");
               end
            end
            next_cycle();
         end
         idx++;
         if (aborted || stop_phase >= 0) begin
            if (!frame_n) begin
               frame_n = 1'b1;
               next_cycle();
            end
            finished = 1'b1;
         end else if (idx >= n) begin
            finished = 1'b1;
         end
      end
      irdy_n = 1'b1;
      frame_n = 1'b1;
      next_cycle();
   endtask

   task automatic wait_drain();
      int tries;
      tries = 0;
      while (exp_adr.size() > 0 || wb_cyc) begin
         if (tries > 2000) fail_stop("Timeout waiting for the Wishbone writes to drain");
         tries++;
         next_cycle();
      end
      repeat (4) next_cycle();
      #1;
   endtask

   // Wishbone slave with random ack delay
   initial begin
      int delay;
      logic [31:0] rnd;
      wb_ack = 1'b0;
      delay = -1;
      forever begin
         @(negedge clk);
         if (wb_ack) begin
            wb_ack = 1'b0;
         end else if (wb_cyc && wb_stb) begin
            if (delay < 0) begin
               rnd = $random(ack_seed);
               delay = fixed_delay ? ACK_DELAY_MAX : int'(rnd % 32'(ACK_DELAY_MAX + 1));
            end
            if (delay == 0) begin
               check_value("wb_we_o", 32'd1, 32'(wb_we));
               obs_adr.push_back(wb_adr);
               obs_dat.push_back(wb_dat);
               obs_sel.push_back(wb_sel);
               wb_ack = 1'b1;
               delay = -1;
            end else begin
               delay--;
            end
         end
      end
   end

   // Compare every acked write against the reference
   initial begin
      forever begin
         @(posedge clk);
         if (obs_adr.size() > 0) begin
            if (exp_adr.size() == 0) fail_stop("Wishbone write with no matching PCI phase");
            check_value("wb_adr_o", exp_adr.pop_front(), obs_adr.pop_front());
            check_value("wb_dat_o", exp_dat.pop_front(), obs_dat.pop_front());
            check_value("wb_sel_o", 32'(exp_sel.pop_front()), 32'(obs_sel.pop_front()));
         end
      end
   end

   initial begin
      int done_cnt, waits, stop_phase, bad_cycle, n;
      logic [31:0] rnd;
      arst_n = 1'b0;
      frame_n = 1'b1;
      irdy_n = 1'b1;
      ad = '0;
      cbe_n = '0;
      par = 1'b0;
      par_due = 1'b0;
      par_next = 1'b0;
      fixed_delay = 0;
      repeat (3) next_cycle();
      arst_n = 1'b1;
      #1;
      cur_test = "reset";
      check_value("tgt_oe_o", 32'd0, 32'(tgt_oe));
      check_value("perr_oe_o", 32'd0, 32'(perr_oe));
      check_value("wb_cyc_o", 32'd0, 32'(wb_cyc));
      check_value("wb_stb_o", 32'd0, 32'(wb_stb));
      check_value("devsel_n_o", 32'd1, 32'(devsel_n));
      check_value("trdy_n_o", 32'd1, 32'(trdy_n));
      check_value("stop_n_o", 32'd1, 32'(stop_n));
      check_value("perr_n_o", 32'd1, 32'(perr_n));

      cur_test = "burst";
      repeat (6) begin
         rnd = $random(seed);
         n = int'(rnd[10:8]) + 1;
         run_burst(PCI_CMD_MEM_WRITE, BAR_BASE + {25'd0, rnd[4:0], 2'b00}, n, -1,
                   done_cnt, waits, stop_phase, bad_cycle);
         check_value("phases", 32'(n), 32'(done_cnt));
         check_value("stop phase", 32'(-1), 32'(stop_phase));
      end
      wait_drain();

      cur_test = "backpressure";
      fixed_delay = 1;
      run_burst(PCI_CMD_MEM_WRITE, BAR_BASE + 32'h40, 12, -1, done_cnt, waits, stop_phase,
                bad_cycle);
      check_value("phases", 32'd12, 32'(done_cnt));
      check_value("stop phase", 32'(-1), 32'(stop_phase));
      if (waits == 0) fail_stop("No wait states inserted while the buffer was full");
      wait_drain();
      fixed_delay = 0;

      cur_test = "miss";
      run_burst(4'b0110, BAR_BASE, 2, -1, done_cnt, waits, stop_phase, bad_cycle);
      check_value("phases", 32'd0, 32'(done_cnt));
      run_burst(PCI_CMD_MEM_WRITE, 32'h9000_0000, 2, -1, done_cnt, waits, stop_phase,
                bad_cycle);
      check_value("phases", 32'd0, 32'(done_cnt));
      wait_drain();

      cur_test = "disconnect";
      run_burst(PCI_CMD_MEM_WRITE, BAR_BASE + 32'hF0, 8, -1, done_cnt, waits, stop_phase,
                bad_cycle);
      check_value("phases", 32'd4, 32'(done_cnt));
      check_value("stop phase", 32'd3, 32'(stop_phase));
      wait_drain();

      cur_test = "parity";
      if (perr_cycles.size() != 0) fail_stop("PERR asserted for a phase with good parity");
      run_burst(PCI_CMD_MEM_WRITE, BAR_BASE + 32'h80, 4, 2, done_cnt, waits, stop_phase,
                bad_cycle);
      check_value("phases", 32'd4, 32'(done_cnt));
      wait_drain();
      check_value("perr count", 32'd1, 32'(perr_cycles.size()));
      check_value("perr cycle", 32'(bad_cycle + 1), 32'(perr_cycles[0]));

      $display("Verification passed");
      $finish;
   end

endmodule

//--- sources.f
pci_wb_pkg.sv
post_wr_if.sv
pci_target_wr.sv
post_wr_fifo.sv
wb_wr_master.sv
pci_wb_bridge.sv
tb_bridge_asserts.sv
tb_pci_wb_bridge.sv

//--- Makefile
SIM := obj_dir/Vtb_pci_wb_bridge

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Verification passed"

$(SIM): sources.f $(shell cat sources.f)
	verilator --binary --timing --assert -j 0 --top-module tb_pci_wb_bridge -f sources.f

clean:
	rm -rf obj_dir
